//--- design/rename_macros.svh
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// Rename group and commit group sizes
`define FETCH_WIDTH 4
`define COMMIT_WIDTH 2

// Register files
`define AREG_NUM 32
`define PREG_NUM 64
`define AREG_WIDTH 5
`define PREG_WIDTH 6

// Registers not holding an architectural value after reset
`define FREELIST_DEPTH (`PREG_NUM - `AREG_NUM)

`endif

//--- design/renamePkg.sv
`include "rename_macros.svh"

package renamePkg;

    typedef logic [`PREG_WIDTH-1:0] pregIdx_t;

    typedef pregIdx_t [`FETCH_WIDTH-1:0] pregVec_t;

    // One decoded instruction
    typedef struct packed {
        logic                   valid;
        logic                   writesRd;
        logic [`AREG_WIDTH-1:0] rd;
        logic [`AREG_WIDTH-1:0] rs1;
        logic [`AREG_WIDTH-1:0] rs2;
    } renameReq_t;

    typedef struct packed {
        logic     valid;
        pregIdx_t prd;
        pregIdx_t ps1;
        pregIdx_t ps2;
        pregIdx_t oldPrd;       // Freed when this instruction commits
    } renameResp_t;

    typedef struct packed {
        logic                   valid;
        logic                   writesRd;
        logic [`AREG_WIDTH-1:0] archRd;
        pregIdx_t               prd;
        pregIdx_t               oldPrd;
    } commitSlot_t;

    typedef renameReq_t [`FETCH_WIDTH-1:0] reqGroup_t;
    typedef renameResp_t [`FETCH_WIDTH-1:0] respGroup_t;
    typedef commitSlot_t [`COMMIT_WIDTH-1:0] commitGroup_t;

endpackage

//--- design/validCompact.sv
`timescale 1ns/1ps

module validCompact #(
    parameter int LANES = 4,
    localparam int IW = (LANES > 1) ? $clog2(LANES) : 1,
    localparam int CW = $clog2(LANES) + 1
) (
    input  logic [LANES-1:0]         mask,
    output logic [LANES-1:0][IW-1:0] idx,
    output logic [CW-1:0]            count
);

    // Each lane gets the number of set lanes below it
    always_comb begin
        logic [CW-1:0] run;
        run = '0;
        for (int i = 0; i < LANES; i++) begin
            idx[i] = run[IW-1:0];   // Only meaningful where mask is set
            run = run + CW'(mask[i]);
        end
        count = run;
    end

endmodule

//--- design/freeList.sv
`timescale 1ns/1ps
`include "rename_macros.svh"

module freeList (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [`FETCH_WIDTH-1:0] needMask,
    input  renamePkg::commitGroup_t commit,
    input  logic                   flush,
    output logic                   full,
    output renamePkg::pregVec_t    allocPrd
);
    import renamePkg::*;

    localparam int PTR_W = $clog2(`FREELIST_DEPTH);
    localparam int CNT_W = PTR_W + 1;
    localparam int AIW = $clog2(`FETCH_WIDTH);
    localparam int RIW = $clog2(`COMMIT_WIDTH);

    pregIdx_t ring [`FREELIST_DEPTH];
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W-1:0] wrPtr;
    logic [CNT_W-1:0] freeCount;
    logic [CNT_W-1:0] inFlight;    // Allocated but not yet committed

    logic [`FETCH_WIDTH-1:0][AIW-1:0]  allocIdx;
    logic [AIW:0]                      needCount;
    logic [`COMMIT_WIDTH-1:0]          relMask;
    logic [`COMMIT_WIDTH-1:0][RIW-1:0] relIdx;
    logic [RIW:0]                      relCount;
    logic [`FETCH_WIDTH-1:0][PTR_W-1:0]  rdIdx;
    logic [`COMMIT_WIDTH-1:0][PTR_W-1:0] wrIdx;
    logic                              doAlloc;
    logic [CNT_W-1:0]                  allocNum;
    logic [CNT_W-1:0]                  relNum;
    logic [CNT_W-1:0]                  rollback;

    validCompact #(.LANES(`FETCH_WIDTH)) allocCompact (
        .mask (needMask),
        .idx  (allocIdx),
        .count(needCount)
    );

    // Only real destinations give a register back
    always_comb begin
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            relMask[i] = commit[i].valid && commit[i].writesRd && (commit[i].archRd != '0);
        end
    end

    validCompact #(.LANES(`COMMIT_WIDTH)) relCompact (
        .mask (relMask),
        .idx  (relIdx),
        .count(relCount)
    );

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            rdIdx[i] = rdPtr + PTR_W'(allocIdx[i]);
            allocPrd[i] = ring[rdIdx[i]];
        end
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            wrIdx[i] = wrPtr + PTR_W'(relIdx[i]);
        end
    end

    assign full = !flush && (CNT_W'(needCount) > freeCount);
    assign doAlloc = !full && !flush;
    assign allocNum = doAlloc ? CNT_W'(needCount) : '0;
    assign relNum = CNT_W'(relCount);
    assign rollback = flush ? inFlight : '0;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `FREELIST_DEPTH; i++) begin
                ring[i] <= pregIdx_t'(`AREG_NUM + i);   // p32 .. p63
            end
            rdPtr <= '0;
            wrPtr <= '0;
            freeCount <= CNT_W'(`FREELIST_DEPTH);
            inFlight <= '0;
        end else begin
            for (int i = 0; i < `COMMIT_WIDTH; i++) begin
                if (relMask[i]) ring[wrIdx[i]] <= commit[i].oldPrd;
            end
            wrPtr <= wrPtr + relNum[PTR_W-1:0];
            // Rolled-back entries are still intact behind rdPtr
            if (flush) rdPtr <= rdPtr - inFlight[PTR_W-1:0];
            else rdPtr <= rdPtr + allocNum[PTR_W-1:0];
            freeCount <= freeCount + rollback + relNum - allocNum;
            inFlight <= flush ? '0 : inFlight + allocNum - relNum;
        end
    end

endmodule

//--- design/mapTable.sv
`timescale 1ns/1ps
`include "rename_macros.svh"

module mapTable (
    input  logic                    clk,
    input  logic                    rstN,
    input  renamePkg::reqGroup_t    req,
    input  logic                    doRename,
    input  renamePkg::pregVec_t     allocPrd,
    input  renamePkg::commitGroup_t commit,
    input  logic                    flush,
    output renamePkg::respGroup_t   resp
);
    import renamePkg::*;

    pregIdx_t specMap [`AREG_NUM];
    pregIdx_t commMap [`AREG_NUM];

    logic [`FETCH_WIDTH-1:0]  writes;
    logic [`COMMIT_WIDTH-1:0] commitWe;

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            writes[i] = req[i].valid && req[i].writesRd && (req[i].rd != '0);
        end
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            commitWe[i] = commit[i].valid && commit[i].writesRd && (commit[i].archRd != '0);
        end
    end

    // Lookup with bypass, later lanes override earlier ones
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            resp[i].valid = req[i].valid;
            resp[i].prd = writes[i] ? allocPrd[i] : '0;
            resp[i].ps1 = specMap[req[i].rs1];
            resp[i].ps2 = specMap[req[i].rs2];
            resp[i].oldPrd = specMap[req[i].rd];   // x0 stays at p0
            for (int j = 0; j < i; j++) begin
                if (writes[j] && req[j].rd == req[i].rs1) resp[i].ps1 = allocPrd[j];
                if (writes[j] && req[j].rd == req[i].rs2) resp[i].ps2 = allocPrd[j];
                if (writes[j] && req[j].rd == req[i].rd) resp[i].oldPrd = allocPrd[j];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `AREG_NUM; i++) begin
                specMap[i] <= pregIdx_t'(i);
                commMap[i] <= pregIdx_t'(i);
            end
        end else begin
            if (flush) begin
                specMap <= commMap;
            end else if (doRename) begin
                // Same rd in two lanes, last lane wins
                for (int i = 0; i < `FETCH_WIDTH; i++) begin
                    if (writes[i]) specMap[req[i].rd] <= allocPrd[i];
                end
            end
            for (int i = 0; i < `COMMIT_WIDTH; i++) begin
                if (commitWe[i]) commMap[commit[i].archRd] <= commit[i].prd;
            end
        end
    end

endmodule

//--- design/renameUnit.sv
`timescale 1ns/1ps
`include "rename_macros.svh"

module renameUnit (
    input  logic                    clk,
    input  logic                    rstN,
    input  renamePkg::reqGroup_t    req,
    output logic                    full,
    output renamePkg::respGroup_t   resp,
    input  renamePkg::commitGroup_t commit,
    input  logic                    flush
);
    import renamePkg::*;

    logic [`FETCH_WIDTH-1:0] needMask;
    logic                    doRename;
    pregVec_t                allocPrd;
    respGroup_t              respNext;
    respGroup_t              respGated;

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            needMask[i] = req[i].valid && req[i].writesRd && (req[i].rd != '0);
        end
    end

    assign doRename = !full && !flush;   // Group taken whole or not at all

    freeList freeList_inst (
        .clk     (clk),
        .rstN    (rstN),
        .needMask(needMask),
        .commit  (commit),
        .flush   (flush),
        .full    (full),
        .allocPrd(allocPrd)
    );

    mapTable mapTable_inst (
        .clk     (clk),
        .rstN    (rstN),
        .req     (req),
        .doRename(doRename),
        .allocPrd(allocPrd),
        .commit  (commit),
        .flush   (flush),
        .resp    (respNext)
    );

    always_comb begin
        respGated = respNext;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            respGated[i].valid = respNext[i].valid && doRename;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `FETCH_WIDTH; i++) resp[i].valid <= 1'b0;
        end else begin
            resp <= respGated;
        end
    end

endmodule

//--- sim/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

//--- sim/renameUnit_assert.sv
`timescale 1ns/1ps
`include "rename_macros.svh"

module renameUnitAssert (
    input logic                             clk,
    input logic                             rstN,
    input logic                             full,
    input logic                             flush,
    input renamePkg::respGroup_t            resp,
    input renamePkg::commitGroup_t          commit,
    input logic [$clog2(`FREELIST_DEPTH):0] freeCount
);

    localparam int CW = $clog2(`FREELIST_DEPTH) + 1;
    localparam logic [CW-1:0] MAX_FREE = CW'(`FREELIST_DEPTH);

    logic [`FETCH_WIDTH-1:0]  respValid;
    logic [`COMMIT_WIDTH-1:0] commitValid;

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) respValid[i] = resp[i].valid;
        for (int i = 0; i < `COMMIT_WIDTH; i++) commitValid[i] = commit[i].valid;
    end

    quietAfterReset: assert property (@(posedge clk) !rstN |=> respValid == '0)
        else $error("resp valid in the cycle after reset");

    // Refused or flushed group leaves nothing behind
    quietAfterRefusal: assert property (@(posedge clk) disable iff (!rstN)
        (full || flush) |=> respValid == '0)
        else $error("resp valid after a refused or flushed group");

    noCommitOnFlush: assert property (@(posedge clk) disable iff (!rstN)
        flush |-> commitValid == '0)
        else $error("commit slot valid together with flush");

    freeCountBound: assert property (@(posedge clk) disable iff (!rstN) freeCount <= MAX_FREE)
        else $error("free count above free-list depth");

endmodule

//--- sim/renameUnitTb.sv
`timescale 1ns/1ps
`include "rename_macros.svh"

module renameUnitTb;
    import renamePkg::*;

    localparam int STIM_CYCLES = 1500;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 100;   // Reset and drain fit well inside

    logic         clk;
    logic         rstN;
    reqGroup_t    req;
    logic         full;
    respGroup_t   resp;
    commitGroup_t commit;
    logic         flush;

    logic [31:0]  lfsr;
    int           cycles = 0;
    pregIdx_t     freeQ[$];
    pregIdx_t     specModel [`AREG_NUM];
    pregIdx_t     commModel [`AREG_NUM];
    commitSlot_t  flightQ[$];    // In-flight instructions in program order
    respGroup_t   expNow;
    respGroup_t   expPrev;
    logic         expFull;

    tbClock clockGen (.clk(clk), .rstN(rstN));

    renameUnit renameUnit_inst (
        .clk   (clk),
        .rstN  (rstN),
        .req   (req),
        .full  (full),
        .resp  (resp),
        .commit(commit),
        .flush (flush)
    );

    bind renameUnit renameUnitAssert renameUnitAssert_inst (
        .clk      (clk),
        .rstN     (rstN),
        .full     (full),
        .flush    (flush),
        .resp     (resp),
        .commit   (commit),
        .freeCount(freeList_inst.freeCount)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Simulation did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $fatal(1, "Timeout");
        end
    end

    // Galois LFSR stepped once per returned bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic reqGroup_t makeGroup();
        reqGroup_t g;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            g[i].valid = (takeBits(2) != 0);      // 3 in 4
            g[i].writesRd = (takeBits(2) != 0);
            g[i].rd = `AREG_WIDTH'(takeBits(`AREG_WIDTH));
            g[i].rs1 = `AREG_WIDTH'(takeBits(`AREG_WIDTH));
            g[i].rs2 = `AREG_WIDTH'(takeBits(`AREG_WIDTH));
        end
        return g;
    endfunction

    task automatic reportError(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1, "Mismatch against the reference model");
    endtask

    task automatic checkResp(input renameResp_t got, input renameResp_t exp, input int lane);
        string gotStr;
        string expStr;
        if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
            gotStr = $sformatf("%b %0d/%0d/%0d/%0d",
                got.valid, got.prd, got.ps1, got.ps2, got.oldPrd);
            expStr = $sformatf("%b %0d/%0d/%0d/%0d",
                exp.valid, exp.prd, exp.ps1, exp.ps2, exp.oldPrd);
            reportError($sformatf("lane %0d valid prd/ps1/ps2/old %s, expected %s",
                lane, gotStr, expStr));
        end
    endtask

    task automatic checkFull(input logic got, input logic exp);
        if (got !== exp) reportError($sformatf("full=%b, expected %b", got, exp));
    endtask

    // Drive one cycle and step the reference model alongside
    task automatic runCycle(input reqGroup_t g, input logic f, input int nCommit);
        commitGroup_t c;
        commitSlot_t slot;
        int need;
        c = '0;
        need = 0;
        for (int k = 0; k < nCommit && k < `COMMIT_WIDTH && flightQ.size() > 0; k++) begin
            c[k] = flightQ.pop_front();
        end
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (g[i].valid && g[i].writesRd && g[i].rd != '0) need++;
        end
        expNow = '0;
        expFull = !f && (need > freeQ.size());
        if (f) begin
            // Uncommitted registers back to the front in original order
            for (int k = flightQ.size() - 1; k >= 0; k--) begin
                if (flightQ[k].prd != '0) freeQ.push_front(flightQ[k].prd);
            end
            flightQ.delete();
            specModel = commModel;
        end else if (!expFull) begin
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                if (g[i].valid) begin
                    expNow[i].valid = 1'b1;
                    expNow[i].ps1 = specModel[g[i].rs1];
                    expNow[i].ps2 = specModel[g[i].rs2];
                    expNow[i].oldPrd = specModel[g[i].rd];
                    if (g[i].writesRd && g[i].rd != '0) begin
                        expNow[i].prd = freeQ.pop_front();
                        specModel[g[i].rd] = expNow[i].prd;
                    end
                    slot = {1'b1, g[i].writesRd, g[i].rd, expNow[i].prd, expNow[i].oldPrd};
                    flightQ.push_back(slot);
                end
            end
        end
        for (int k = 0; k < `COMMIT_WIDTH; k++) begin
            if (c[k].valid && c[k].writesRd && c[k].archRd != '0) begin
                commModel[c[k].archRd] = c[k].prd;
                freeQ.push_back(c[k].oldPrd);   // Usable next cycle
            end
        end
        req <= g;
        commit <= c;
        flush <= f;
    endtask

    initial begin
        reqGroup_t group;
        logic holding;
        logic f;
        int nCommit;
        req = '0;
        commit = '0;
        flush = 1'b0;
        lfsr = 32'h6f3d30db;
        for (int a = 0; a < `AREG_NUM; a++) begin
            specModel[a] = pregIdx_t'(a);
            commModel[a] = pregIdx_t'(a);
        end
        for (int k = 0; k < `FREELIST_DEPTH; k++) freeQ.push_back(pregIdx_t'(`AREG_NUM + k));
        expPrev = '0;
        group = '0;
        holding = 1'b0;
        wait (rstN === 1'b1);
        for (int n = 0; n <= STIM_CYCLES; n++) begin
            @(posedge clk);
            if (!holding) group = makeGroup();   // Refused group is held
            f = (takeBits(8) < 6);
            nCommit = f ? 0 : int'(takeBits(2));
            if (n == STIM_CYCLES) begin
                group = '0;
                f = 1'b0;
                nCommit = 0;
            end
            runCycle(group, f, nCommit);
            holding = expFull;
            @(negedge clk);
            checkFull(full, expFull);
            for (int i = 0; i < `FETCH_WIDTH; i++) checkResp(resp[i], expPrev[i], i);
            expPrev = expNow;
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- all.f
+incdir+design
design/renamePkg.sv
design/validCompact.sv
design/freeList.sv
design/mapTable.sv
design/renameUnit.sv
sim/tbClock.sv
sim/renameUnit_assert.sv
sim/renameUnitTb.sv

//--- Makefile
TOP = renameUnitTb

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): all.f design/*.sv design/*.svh sim/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir

.PHONY: all lint clean
